/* Makefile */
VERILATOR ?= verilator
TOP       := tb_lsu_top
FILELIST  := filelist.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)

SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/lsu_cfg.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

/* filelist.f */
+incdir+include
source/lsu_pkg.sv
source/load_align.sv
source/data_mem.sv
source/lsu.sv
source/lsu_top.sv
tb/tb_lsu_top.sv

/* include/lsu_cfg.svh */
//////////////////////////////
// LSU configuration
// Data width, data memory depth
// and memory read latency
//////////////////////////////
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data and address width
`define XLEN 32

// Data memory depth in 32-bit words
`define DMEM_WORDS 256

// Cycles from read address accepted to rd_valid, at least 1
`define DMEM_RD_LAT 2

`endif

/* source/data_mem.sv */
//////////////////////////////
// Data memory
// Core bus slave with byte strobes,
// fixed read latency, write response
// and error for out-of-range access
//////////////////////////////
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_mem (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic [`XLEN-1:0]       rd_addr_i,
  input  lsu_pkg::cb_size_t      rd_size_i,
  input  logic                   rd_addr_valid_i,
  output logic                   rd_addr_ready_o,
  output logic [`XLEN-1:0]       rd_data_o,
  output lsu_pkg::cb_resp_t      rd_resp_o,
  output logic                   rd_valid_o,
  input  logic                   rd_ready_i,
  input  logic [`XLEN-1:0]       wr_addr_i,
  input  lsu_pkg::cb_size_t      wr_size_i,
  input  logic                   wr_addr_valid_i,
  output logic                   wr_addr_ready_o,
  input  logic [`XLEN-1:0]       wr_data_i,
  input  logic [`XLEN/8-1:0]     wr_strobe_i,
  input  logic                   wr_data_valid_i,
  output logic                   wr_data_ready_o,
  output logic                   wr_resp_valid_o,
  output lsu_pkg::cb_resp_t      wr_resp_error_o,
  input  logic                   wr_resp_ready_i
);
  typedef enum logic [1:0] {IDLE, RD_WAIT, WR_DATA, WR_RESP} mem_st_t;

  localparam int IDX_W = $clog2(`DMEM_WORDS);
  localparam int CNT_W = $clog2(`DMEM_RD_LAT + 1);
  localparam logic [`XLEN-1:0] MEM_BYTES = `XLEN'(`DMEM_WORDS * 4);

  logic [`XLEN-1:0]  mem [`DMEM_WORDS];
  mem_st_t           st_ff, next_st;
  logic [CNT_W-1:0]  cnt_ff;
  logic [IDX_W-1:0]  idx_ff;
  logic              err_ff;
  lsu_pkg::cb_size_t wsize_ff;
  logic              rd_fire, wr_fire, wd_fire, wd_err;

  function automatic logic [2:0] size_bytes(lsu_pkg::cb_size_t sz);
    case (sz)
      lsu_pkg::CB_BYTE:      return 3'd1;
      lsu_pkg::CB_HALF_WORD: return 3'd2;
      lsu_pkg::CB_WORD:      return 3'd4;
      default:               return 3'd0;
    endcase
  endfunction

  function automatic logic [2:0] strb_cnt(logic [`XLEN/8-1:0] strb);
    logic [2:0] n;
    n = 3'd0;
    for (int i = 0; i < `XLEN/8; i++) begin
      n = n + 3'(strb[i]);
    end
    return n;
  endfunction

  // Read has priority when both address channels are valid
  assign rd_addr_ready_o = (st_ff == IDLE);
  assign wr_addr_ready_o = (st_ff == IDLE) && !rd_addr_valid_i;
  assign wr_data_ready_o = (st_ff == WR_DATA);
  assign rd_valid_o      = (st_ff == RD_WAIT) && (cnt_ff == '0);
  assign wr_resp_valid_o = (st_ff == WR_RESP);

  assign rd_fire = rd_addr_valid_i && rd_addr_ready_o;
  assign wr_fire = wr_addr_valid_i && wr_addr_ready_o;
  assign wd_fire = wr_data_valid_i && wr_data_ready_o;
  // More strobed bytes than the size allows is also an error
  assign wd_err  = err_ff || (strb_cnt(wr_strobe_i) > size_bytes(wsize_ff));

  assign rd_data_o       = err_ff ? '0 : mem[idx_ff];
  assign rd_resp_o       = err_ff ? lsu_pkg::CB_SLVERR : lsu_pkg::CB_OKAY;
  assign wr_resp_error_o = err_ff ? lsu_pkg::CB_SLVERR : lsu_pkg::CB_OKAY;

  always_comb begin
    next_st = st_ff;
    case (st_ff)
      IDLE: begin
        if (rd_fire) begin
          next_st = RD_WAIT;
        end else if (wr_fire) begin
          next_st = WR_DATA;
        end
      end
      RD_WAIT: if (rd_valid_o && rd_ready_i) next_st = IDLE;
      WR_DATA: if (wd_fire) next_st = WR_RESP;
      default: if (wr_resp_ready_i) next_st = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      st_ff  <= IDLE;
      cnt_ff <= '0;
    end else begin
      st_ff <= next_st;
      if (rd_fire) begin
        cnt_ff <= CNT_W'(`DMEM_RD_LAT - 1);
      end else if (cnt_ff != '0) begin
        cnt_ff <= cnt_ff - 1'b1;
      end
    end
  end

  // Request capture and byte writes
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      idx_ff <= rd_addr_i[IDX_W+1:2];
      err_ff <= (rd_addr_i >= MEM_BYTES) || (size_bytes(rd_size_i) == 3'd0);
    end else if (wr_fire) begin
      idx_ff   <= wr_addr_i[IDX_W+1:2];
      err_ff   <= (wr_addr_i >= MEM_BYTES);
      wsize_ff <= wr_size_i;
    end else if (wd_fire) begin
      err_ff <= wd_err;
      for (int i = 0; i < `XLEN/8; i++) begin
        if (wr_strobe_i[i] && !wd_err) begin
          mem[idx_ff][i*8 +: 8] <= wr_data_i[i*8 +: 8];
        end
      end
    end
  end

endmodule

/* source/load_align.sv */
//////////////////////////////
// Load aligner
// Shifts the read word by the byte
// offset, then sign or zero extends
//////////////////////////////
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module load_align (
  input  logic [`XLEN-1:0]  rdata_i,
  input  lsu_pkg::lsu_w_t   width_i,
  input  logic [1:0]        offset_i,
  output logic [`XLEN-1:0]  data_o
);
  logic [`XLEN-1:0] shifted;

  // Selected lane moves down to bit 0
  assign shifted = rdata_i >> {offset_i, 3'b000};

  always_comb begin
    case (width_i)
      lsu_pkg::RV_LSU_B: begin
        data_o = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::RV_LSU_H: begin
        data_o = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      lsu_pkg::RV_LSU_BU: begin
        data_o = {{(`XLEN-8){1'b0}}, shifted[7:0]};
      end
      lsu_pkg::RV_LSU_HU: begin
        data_o = {{(`XLEN-16){1'b0}}, shifted[15:0]};
      end
      // Full word, offset is zero for aligned words
      default: begin
        data_o = shifted;
      end
    endcase
  end

endmodule

/* source/lsu.sv */
//////////////////////////////
// Load/store unit
// Address phase on the core bus, then
// data phase with byte-lane store data
// and strobes, or read data capture.
// Raises back-pressure to execute stage
//////////////////////////////
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu (
  input  logic                   clk,
  input  logic                   arst_n_i,
  // Execute stage
  input  lsu_pkg::lsu_op_t       op_typ_i,
  input  lsu_pkg::lsu_w_t        width_i,
  input  logic [`XLEN-1:0]       addr_i,
  input  logic [`XLEN-1:0]       wdata_i,
  // Core bus read channels
  output logic [`XLEN-1:0]       rd_addr_o,
  output lsu_pkg::cb_size_t      rd_size_o,
  output logic                   rd_addr_valid_o,
  input  logic                   rd_addr_ready_i,
  input  logic [`XLEN-1:0]       rd_data_i,
  input  lsu_pkg::cb_resp_t      rd_resp_i,
  input  logic                   rd_valid_i,
  output logic                   rd_ready_o,
  // Core bus write channels
  output logic [`XLEN-1:0]       wr_addr_o,
  output lsu_pkg::cb_size_t      wr_size_o,
  output logic                   wr_addr_valid_o,
  input  logic                   wr_addr_ready_i,
  output logic [`XLEN-1:0]       wr_data_o,
  output logic [`XLEN/8-1:0]     wr_strobe_o,
  output logic                   wr_data_valid_o,
  input  logic                   wr_data_ready_i,
  input  logic                   wr_resp_valid_i,
  input  lsu_pkg::cb_resp_t      wr_resp_error_i,
  output logic                   wr_resp_ready_o,
  // Stall and write-back
  output logic                   lsu_bp_o,
  output logic                   wb_valid_o,
  output lsu_pkg::lsu_op_t       wb_op_o,
  output lsu_pkg::lsu_w_t        wb_width_o,
  output logic [1:0]             wb_offset_o,
  output logic [`XLEN-1:0]       rdata_o,
  output logic                   txn_error_o
);
  lsu_pkg::lsu_op_t  op_ff, next_op;
  lsu_pkg::lsu_w_t   width_ff;
  logic [1:0]        offset_ff;
  logic [`XLEN-1:0]  wdata_ff;
  logic [`XLEN-1:0]  lane_data;
  logic              wr_resp_ff, next_wresp;
  logic              new_txn, rd_txn, wr_txn;
  logic              dp_load, dp_store;
  logic              bp_addr, bp_data, bp_wr_resp, dp_stall;

  function automatic lsu_pkg::cb_size_t size_txn(lsu_pkg::lsu_w_t w);
    case (w)
      lsu_pkg::RV_LSU_B, lsu_pkg::RV_LSU_BU: return lsu_pkg::CB_BYTE;
      lsu_pkg::RV_LSU_H, lsu_pkg::RV_LSU_HU: return lsu_pkg::CB_HALF_WORD;
      default:                               return lsu_pkg::CB_WORD;
    endcase
  endfunction

  // Base mask by width, moved up to the byte offset
  function automatic logic [`XLEN/8-1:0] mask_strobe(lsu_pkg::lsu_w_t w, logic [1:0] ofs);
    logic [`XLEN/8-1:0] mask;
    case (w)
      lsu_pkg::RV_LSU_B, lsu_pkg::RV_LSU_BU: mask = 4'b0001;
      lsu_pkg::RV_LSU_H, lsu_pkg::RV_LSU_HU: mask = 4'b0011;
      default:                               mask = 4'b1111;
    endcase
    return mask << ofs;
  endfunction

  always_comb begin
    new_txn  = (op_typ_i != lsu_pkg::NO_LSU);
    rd_txn   = (op_typ_i == lsu_pkg::LSU_LOAD);
    wr_txn   = (op_typ_i == lsu_pkg::LSU_STORE);
    dp_load  = (op_ff == lsu_pkg::LSU_LOAD);
    dp_store = (op_ff == lsu_pkg::LSU_STORE);

    // Back-pressure per channel
    bp_addr    = new_txn && (rd_txn ? ~rd_addr_ready_i : ~wr_addr_ready_i);
    bp_data    = dp_store ? (~wr_resp_ff && ~wr_data_ready_i) : (dp_load && ~rd_valid_i);
    // A store holds the stage until its response returns
    bp_wr_resp = dp_store && ~(wr_resp_ff && wr_resp_valid_i);
    dp_stall   = bp_data || bp_wr_resp;
    lsu_bp_o   = bp_addr || dp_stall;

    next_wresp = wr_resp_ff ? ~wr_resp_valid_i : (dp_store && wr_data_ready_i);
  end

  // Address phase, word aligned
  assign rd_addr_o       = {addr_i[`XLEN-1:2], 2'b00};
  assign wr_addr_o       = {addr_i[`XLEN-1:2], 2'b00};
  assign rd_size_o       = size_txn(width_i);
  assign wr_size_o       = size_txn(width_i);
  assign rd_addr_valid_o = rd_txn && ~dp_stall;
  assign wr_addr_valid_o = wr_txn && ~dp_stall;
  assign rd_ready_o      = 1'b1;
  assign wr_resp_ready_o = 1'b1;

  // Data phase, store data placed on its byte lanes
  always_comb begin
    lane_data   = wdata_ff << {offset_ff, 3'b000};
    wr_strobe_o = mask_strobe(width_ff, offset_ff);
    for (int i = 0; i < `XLEN/8; i++) begin
      if (!wr_strobe_o[i]) begin
        lane_data[i*8 +: 8] = 8'h00;
      end
    end
  end

  assign wr_data_o       = lane_data;
  assign wr_data_valid_o = dp_store && ~wr_resp_ff;

  // Write-back
  assign wb_valid_o  = dp_load ? rd_valid_i : (dp_store && wr_resp_ff && wr_resp_valid_i);
  assign txn_error_o = wb_valid_o && (dp_load ? (rd_resp_i != lsu_pkg::CB_OKAY) :
                                                (wr_resp_error_i != lsu_pkg::CB_OKAY));
  assign wb_op_o     = op_ff;
  assign wb_width_o  = width_ff;
  assign wb_offset_o = offset_ff;
  assign rdata_o     = rd_data_i;

  // Retire a finished data phase even when the next op is held off
  always_comb begin
    next_op = op_ff;
    if (!lsu_bp_o) begin
      next_op = op_typ_i;
    end else if (wb_valid_o) begin
      next_op = lsu_pkg::NO_LSU;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_ff      <= lsu_pkg::NO_LSU;
      wr_resp_ff <= 1'b0;
    end else begin
      op_ff      <= next_op;
      wr_resp_ff <= next_wresp;
    end
  end

  always_ff @(posedge clk) begin
    if (!lsu_bp_o) begin
      width_ff  <= width_i;
      offset_ff <= addr_i[1:0];
      wdata_ff  <= wdata_i;
    end
  end

endmodule

/* source/lsu_pkg.sv */
//////////////////////////////
// LSU package
// Operation, access width, core bus
// size and response encodings
//////////////////////////////
package lsu_pkg;

  // Memory operation from execute stage
  typedef enum logic [1:0] {
    NO_LSU,
    LSU_LOAD,
    LSU_STORE
  } lsu_op_t;

  // Access width as decoded from funct3
  typedef enum logic [2:0] {
    RV_LSU_B,
    RV_LSU_H,
    RV_LSU_W,
    RV_LSU_BU,
    RV_LSU_HU
  } lsu_w_t;

  // Transfer size on the core bus
  typedef enum logic [1:0] {
    CB_BYTE,
    CB_HALF_WORD,
    CB_WORD
  } cb_size_t;

  // Slave response
  typedef enum logic [1:0] {
    CB_OKAY,
    CB_SLVERR
  } cb_resp_t;

endpackage

/* source/lsu_top.sv */
//////////////////////////////
// LSU subsystem top
// Load/store unit, data memory and
// load aligner on one core bus
//////////////////////////////
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
  input  logic               clk,
  input  logic               arst_n_i,
  input  lsu_pkg::lsu_op_t   op_typ_i,
  input  lsu_pkg::lsu_w_t    width_i,
  input  logic [`XLEN-1:0]   addr_i,
  input  logic [`XLEN-1:0]   wdata_i,
  output logic               lsu_bp_o,
  output logic               wb_valid_o,
  output lsu_pkg::lsu_op_t   wb_op_o,
  output logic [`XLEN-1:0]   wb_data_o,
  output logic               txn_error_o
);
  // Core bus
  logic [`XLEN-1:0]    rd_addr, wr_addr, rd_data, wr_data;
  lsu_pkg::cb_size_t   rd_size, wr_size;
  lsu_pkg::cb_resp_t   rd_resp, wr_resp_error;
  logic [`XLEN/8-1:0]  wr_strobe;
  logic                rd_addr_valid, rd_addr_ready, rd_valid, rd_ready;
  logic                wr_addr_valid, wr_addr_ready, wr_data_valid, wr_data_ready;
  logic                wr_resp_valid, wr_resp_ready;
  // Write-back fields into the aligner
  lsu_pkg::lsu_w_t     wb_width;
  logic [1:0]          wb_offset;
  logic [`XLEN-1:0]    lsu_rdata;

  lsu u_lsu (
    .clk, .arst_n_i, .op_typ_i, .width_i, .addr_i, .wdata_i,
    .rd_addr_o(rd_addr), .rd_size_o(rd_size), .rd_addr_valid_o(rd_addr_valid),
    .rd_addr_ready_i(rd_addr_ready), .rd_data_i(rd_data), .rd_resp_i(rd_resp),
    .rd_valid_i(rd_valid), .rd_ready_o(rd_ready),
    .wr_addr_o(wr_addr), .wr_size_o(wr_size), .wr_addr_valid_o(wr_addr_valid),
    .wr_addr_ready_i(wr_addr_ready), .wr_data_o(wr_data), .wr_strobe_o(wr_strobe),
    .wr_data_valid_o(wr_data_valid), .wr_data_ready_i(wr_data_ready),
    .wr_resp_valid_i(wr_resp_valid), .wr_resp_error_i(wr_resp_error),
    .wr_resp_ready_o(wr_resp_ready),
    .lsu_bp_o, .wb_valid_o, .wb_op_o, .wb_width_o(wb_width), .wb_offset_o(wb_offset),
    .rdata_o(lsu_rdata), .txn_error_o
  );

  data_mem u_dmem (
    .clk, .arst_n_i,
    .rd_addr_i(rd_addr), .rd_size_i(rd_size), .rd_addr_valid_i(rd_addr_valid),
    .rd_addr_ready_o(rd_addr_ready), .rd_data_o(rd_data), .rd_resp_o(rd_resp),
    .rd_valid_o(rd_valid), .rd_ready_i(rd_ready),
    .wr_addr_i(wr_addr), .wr_size_i(wr_size), .wr_addr_valid_i(wr_addr_valid),
    .wr_addr_ready_o(wr_addr_ready), .wr_data_i(wr_data), .wr_strobe_i(wr_strobe),
    .wr_data_valid_i(wr_data_valid), .wr_data_ready_o(wr_data_ready),
    .wr_resp_valid_o(wr_resp_valid), .wr_resp_error_o(wr_resp_error),
    .wr_resp_ready_i(wr_resp_ready)
  );

  load_align u_align (
    .rdata_i  (lsu_rdata),
    .width_i  (wb_width),
    .offset_i (wb_offset),
    .data_o   (wb_data_o)
  );

endmodule

/* tb/tb_lsu_top.sv */
//////////////////////////////
// LSU subsystem testbench
// Table of loads and stores, checked
// against a byte reference memory
//////////////////////////////
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu_top;
  localparam int MAX_ENTRIES = 64;
  localparam int WAIT_LIMIT  = 50;
  localparam int MEM_BYTES   = `DMEM_WORDS * 4;
  localparam int LOAD_WAIT   = `DMEM_RD_LAT - 1;

  logic              clk;
  logic              arst_n_i;
  lsu_pkg::lsu_op_t  op_typ_i;
  lsu_pkg::lsu_w_t   width_i;
  logic [`XLEN-1:0]  addr_i;
  logic [`XLEN-1:0]  wdata_i;
  logic              lsu_bp_o;
  logic              wb_valid_o;
  lsu_pkg::lsu_op_t  wb_op_o;
  logic [`XLEN-1:0]  wb_data_o;
  logic              txn_error_o;

  // Stimulus table with the expected error flag per entry
  lsu_pkg::lsu_op_t  tbl_op   [MAX_ENTRIES];
  lsu_pkg::lsu_w_t   tbl_w    [MAX_ENTRIES];
  logic [`XLEN-1:0]  tbl_addr [MAX_ENTRIES];
  logic [`XLEN-1:0]  tbl_data [MAX_ENTRIES];
  logic              tbl_err  [MAX_ENTRIES];
  int                n_entries;

  logic [7:0]        ref_mem [MEM_BYTES];
  logic [15:0]       lfsr_state;

  lsu_top u_dut (
    .clk, .arst_n_i, .op_typ_i, .width_i, .addr_i, .wdata_i,
    .lsu_bp_o, .wb_valid_o, .wb_op_o, .wb_data_o, .txn_error_o
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Galois LFSR with taps 16 14 13 11 stepped once per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  function automatic int width_bytes(lsu_pkg::lsu_w_t w);
    case (w)
      lsu_pkg::RV_LSU_B, lsu_pkg::RV_LSU_BU: return 1;
      lsu_pkg::RV_LSU_H, lsu_pkg::RV_LSU_HU: return 2;
      default:                               return 4;
    endcase
  endfunction

  // Little-endian load result from the reference bytes
  function automatic logic [31:0] expect_load(lsu_pkg::lsu_w_t w, logic [31:0] a);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = ref_mem[a];
    b1 = ref_mem[a + 1];
    case (w)
      lsu_pkg::RV_LSU_B:  return {{24{b0[7]}}, b0};
      lsu_pkg::RV_LSU_BU: return {24'h0, b0};
      lsu_pkg::RV_LSU_H:  return {{16{b1[7]}}, b1, b0};
      lsu_pkg::RV_LSU_HU: return {16'h0, b1, b0};
      default:            return {ref_mem[a + 3], ref_mem[a + 2], b1, b0};
    endcase
  endfunction

  task automatic add_entry(lsu_pkg::lsu_op_t op, lsu_pkg::lsu_w_t w,
                           logic [31:0] addr, logic [31:0] data);
    tbl_op[n_entries]   = op;
    tbl_w[n_entries]    = w;
    tbl_addr[n_entries] = addr;
    tbl_data[n_entries] = data;
    tbl_err[n_entries]  = (addr >= 32'(MEM_BYTES));
    n_entries++;
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("TESTS FAILED");
    $fatal(1, "Timeout");
  endtask

  task automatic build_table();
    logic [31:0]     a;
    lsu_pkg::lsu_w_t w;
    n_entries = 0;
    // Word round trip over words 0 to 7, which also sets up the test region
    for (int i = 0; i < 8; i++) begin
      a = 32'(i * 4);
      add_entry(lsu_pkg::LSU_STORE, lsu_pkg::RV_LSU_W, a, (a + 32'h1) * 32'h9E3779B9);
    end
    for (int i = 0; i < 8; i++) begin
      add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_W, 32'(i * 4), '0);
    end
    // Byte stores in word 2 and half stores in word 3
    for (int i = 0; i < 4; i++) begin
      add_entry(lsu_pkg::LSU_STORE, lsu_pkg::RV_LSU_B, 32'(8 + i), take_bits(8));
    end
    add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_W, 32'd8, '0);
    for (int i = 0; i < 3; i++) begin
      add_entry(lsu_pkg::LSU_STORE, lsu_pkg::RV_LSU_H, 32'(12 + i), take_bits(16));
      add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_W, 32'd12, '0);
    end
    // Both signs in every lane of word 4
    add_entry(lsu_pkg::LSU_STORE, lsu_pkg::RV_LSU_W, 32'd16, 32'h80FF7F80);
    for (int i = 0; i < 4; i++) begin
      add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_B, 32'(16 + i), '0);
      add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_BU, 32'(16 + i), '0);
    end
    for (int i = 0; i < 3; i++) begin
      add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_H, 32'(16 + i), '0);
      add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_HU, 32'(16 + i), '0);
    end
    // Out-of-range stores alias words 0 and 1 in the index bits
    add_entry(lsu_pkg::LSU_STORE, lsu_pkg::RV_LSU_W, 32'(MEM_BYTES), 32'hF00DF00D);
    add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_W, 32'(MEM_BYTES), '0);
    add_entry(lsu_pkg::LSU_STORE, lsu_pkg::RV_LSU_B, 32'(MEM_BYTES + 5), 32'h000000EE);
    add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_HU, 32'hFFFF_FFF0, '0);
    add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_W, 32'd0, '0);
    add_entry(lsu_pkg::LSU_LOAD, lsu_pkg::RV_LSU_W, 32'd4, '0);
    // Random mix inside words 0 to 7
    for (int i = 0; i < 14; i++) begin
      if (take_bits(1) == 32'h1) begin
        w = lsu_pkg::lsu_w_t'(take_bits(2) % 3);
      end else begin
        w = lsu_pkg::lsu_w_t'(take_bits(3) % 5);
      end
      a = take_bits(3) << 2;
      if (width_bytes(w) == 1) begin
        a = a + take_bits(2);
      end else if (width_bytes(w) == 2) begin
        a = a + (take_bits(2) % 3);
      end
      if (i % 2 == 0) begin
        add_entry(lsu_pkg::LSU_STORE, w, a, take_bits(32));
      end else begin
        add_entry(lsu_pkg::LSU_LOAD, w, a, '0);
      end
    end
  endtask

  initial begin
    int          waited;
    int          stalls;
    logic        accepted;
    logic        done;
    lfsr_state = 16'd78;
    arst_n_i   = 1'b0;
    op_typ_i   = lsu_pkg::NO_LSU;
    width_i    = lsu_pkg::RV_LSU_W;
    addr_i     = '0;
    wdata_i    = '0;
    build_table();
    repeat (8) @(posedge clk);
    arst_n_i <= 1'b1;
    @(posedge clk);
    check_value("lsu_bp_o", 32'(lsu_bp_o), 32'h0);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'h0);
    check_value("txn_error_o", 32'(txn_error_o), 32'h0);

    for (int e = 0; e < n_entries; e++) begin
      op_typ_i <= tbl_op[e];
      width_i  <= tbl_w[e];
      addr_i   <= tbl_addr[e];
      wdata_i  <= tbl_data[e];
      // Taken on the first edge with back-pressure low
      accepted = 1'b0;
      waited   = 0;
      while (!accepted) begin
        @(posedge clk);
        check_value("wb_valid_o", 32'(wb_valid_o), 32'h0);
        accepted = !lsu_bp_o;
        waited++;
        if (!accepted && waited >= WAIT_LIMIT) begin
          report_timeout("the operation to be accepted");
        end
      end
      op_typ_i <= lsu_pkg::NO_LSU;

      // Stage stays stalled until write-back
      done   = 1'b0;
      stalls = 0;
      while (!done) begin
        @(posedge clk);
        done = wb_valid_o;
        if (!done) begin
          check_value("lsu_bp_o", 32'(lsu_bp_o), 32'h1);
          stalls++;
          if (stalls >= WAIT_LIMIT) begin
            report_timeout("wb_valid_o");
          end
        end
      end
      check_value("lsu_bp_o stall cycles", 32'(stalls),
                  (tbl_op[e] == lsu_pkg::LSU_LOAD) ? 32'(LOAD_WAIT) : 32'h1);
      check_value("wb_op_o", 32'(wb_op_o), 32'(tbl_op[e]));
      check_value("txn_error_o", 32'(txn_error_o), 32'(tbl_err[e]));
      if (!tbl_err[e]) begin
        if (tbl_op[e] == lsu_pkg::LSU_LOAD) begin
          check_value("wb_data_o", wb_data_o, expect_load(tbl_w[e], tbl_addr[e]));
        end else begin
          for (int i = 0; i < width_bytes(tbl_w[e]); i++) begin
            ref_mem[tbl_addr[e] + i] = tbl_data[e][i*8 +: 8];
          end
        end
      end
    end

    // Last write-back is a single pulse
    @(posedge clk);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'h0);
    $display("TESTS PASSED");
    $finish;
  end

endmodule
